/* filelist.f */
+incdir+test
logic/mips_pkg.sv
logic/decode_exec_if.sv
logic/exec_result_if.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/mips_top.sv
test/tb_mips_top.sv

/* logic/decode_exec_if.sv */
`timescale 1ns/10ps

interface decode_exec_if;
    import mips_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [ALUOP_W-1:0]    aluop;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic                  wr_en;      // low on a bubble.
    logic [REG_ADDR_W-1:0] wr_addr;

    modport decode (
        output pc, aluop, operand_a, operand_b, wr_en, wr_addr
    );

    modport execute (
        input pc, aluop, operand_a, operand_b, wr_en, wr_addr
    );

endinterface

/* logic/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  mips_pkg::instr_u                instr_i,
    input  logic [mips_pkg::XLEN-1:0]       instr_pc_i,
    input  logic                            instr_valid_i,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_o,
    input  logic [mips_pkg::XLEN-1:0]       rs_data_i,
    input  logic [mips_pkg::XLEN-1:0]       rt_data_i,
    exec_result_if.bypass                   fwd,
    decode_exec_if.decode                   to_ex
);
    import mips_pkg::*;

    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_zext;
    logic [XLEN-1:0]       imm_upper;
    logic [XLEN-1:0]       shamt_ext;
    logic [ALUOP_W-1:0]    aluop_d;
    logic [XLEN-1:0]       op_a_d;
    logic [XLEN-1:0]       op_b_d;
    logic [REG_ADDR_W-1:0] dest_d;
    logic                  known_d;

    assign rs_addr_o = instr_i.r.rs;
    assign rt_addr_o = instr_i.r.rt;

    // newest value comes from execute.
    assign rs_val = (fwd.wr_en && (fwd.wr_addr == instr_i.r.rs)) ? fwd.wr_data : rs_data_i;
    assign rt_val = (fwd.wr_en && (fwd.wr_addr == instr_i.r.rt)) ? fwd.wr_data : rt_data_i;

    assign imm_sext  = {{(XLEN-IMM_W){instr_i.i.imm[IMM_W-1]}}, instr_i.i.imm};
    assign imm_zext  = {{(XLEN-IMM_W){1'b0}}, instr_i.i.imm};
    assign imm_upper = {instr_i.i.imm, {(XLEN-IMM_W){1'b0}}};
    assign shamt_ext = {{(XLEN-SHAMT_W){1'b0}}, instr_i.r.shamt};

    ////////////////////
    // field decode
    ////////////////////

    always_comb begin
        aluop_d = ALU_ADD;
        op_a_d  = rs_val;
        op_b_d  = rt_val;
        dest_d  = instr_i.i.rt;  // I-type writes rt.
        known_d = 1'b1;
        case (instr_i.r.opcode)
            OP_SPECIAL: begin
                dest_d = instr_i.r.rd;
                case (instr_i.r.funct)
                    FUNCT_ADDU: aluop_d = ALU_ADD;
                    FUNCT_SUBU: aluop_d = ALU_SUB;
                    FUNCT_AND:  aluop_d = ALU_AND;
                    FUNCT_OR:   aluop_d = ALU_OR;
                    FUNCT_XOR:  aluop_d = ALU_XOR;
                    FUNCT_NOR:  aluop_d = ALU_NOR;
                    FUNCT_SLT:  aluop_d = ALU_SLT;
                    FUNCT_SLTU: aluop_d = ALU_SLTU;
                    FUNCT_SLL:  aluop_d = ALU_SLL;
                    FUNCT_SRL:  aluop_d = ALU_SRL;
                    FUNCT_SRA:  aluop_d = ALU_SRA;
                    default:    known_d = 1'b0;
                endcase
                if ((aluop_d == ALU_SLL) || (aluop_d == ALU_SRL) || (aluop_d == ALU_SRA)) begin
                    op_a_d = rt_val;  // shift rt by shamt.
                    op_b_d = shamt_ext;
                end
            end
            OP_ADDIU: op_b_d = imm_sext;
            OP_SLTI: begin
                aluop_d = ALU_SLT;
                op_b_d  = imm_sext;
            end
            OP_ANDI: begin
                aluop_d = ALU_AND;
                op_b_d  = imm_zext;
            end
            OP_ORI: begin
                aluop_d = ALU_OR;
                op_b_d  = imm_zext;
            end
            OP_XORI: begin
                aluop_d = ALU_XOR;
                op_b_d  = imm_zext;
            end
            OP_LUI: begin
                aluop_d = ALU_OR;
                op_a_d  = '0;
                op_b_d  = imm_upper;
            end
            default: known_d = 1'b0;
        endcase
    end

    ////////////////////
    // decode/execute reg
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            to_ex.wr_en <= 1'b0;
        end else begin
            to_ex.wr_en <= instr_valid_i && known_d && (dest_d != '0);
        end
    end

    always_ff @(posedge clk) begin
        to_ex.pc        <= instr_pc_i;
        to_ex.aluop     <= aluop_d;
        to_ex.operand_a <= op_a_d;
        to_ex.operand_b <= op_b_d;
        to_ex.wr_addr   <= dest_d;
    end

endmodule

/* logic/exec_result_if.sv */
`timescale 1ns/10ps

interface exec_result_if;
    import mips_pkg::*;

    logic [XLEN-1:0]       pc;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    modport execute (output pc, wr_en, wr_addr, wr_data);

    modport result (input pc, wr_en, wr_addr, wr_data);

    // forwarding path back to decode.
    modport bypass (input wr_en, wr_addr, wr_data);

endinterface

/* logic/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    decode_exec_if.execute from_id,
    exec_result_if.execute to_wb
);
    import mips_pkg::*;

    logic [XLEN-1:0]    alu_result;
    logic [SHAMT_W-1:0] sa;
    logic               lt_signed;
    logic               lt_unsigned;

    assign sa          = from_id.operand_b[SHAMT_W-1:0];  // low bits only.
    assign lt_signed   = $signed(from_id.operand_a) < $signed(from_id.operand_b);
    assign lt_unsigned = from_id.operand_a < from_id.operand_b;

    ////////////////////
    // alu
    ////////////////////

    always_comb begin
        case (from_id.aluop)
            ALU_ADD:  alu_result = from_id.operand_a + from_id.operand_b;  // wraps.
            ALU_SUB:  alu_result = from_id.operand_a - from_id.operand_b;
            ALU_AND:  alu_result = from_id.operand_a & from_id.operand_b;
            ALU_OR:   alu_result = from_id.operand_a | from_id.operand_b;
            ALU_XOR:  alu_result = from_id.operand_a ^ from_id.operand_b;
            ALU_NOR:  alu_result = ~(from_id.operand_a | from_id.operand_b);
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  alu_result = from_id.operand_a << sa;
            ALU_SRL:  alu_result = from_id.operand_a >> sa;
            ALU_SRA:  alu_result = $unsigned($signed(from_id.operand_a) >>> sa);
            default:  alu_result = '0;
        endcase
    end

    // write-back intent passes through.
    assign to_wb.pc      = from_id.pc;
    assign to_wb.wr_en   = from_id.wr_en;
    assign to_wb.wr_addr = from_id.wr_addr;
    assign to_wb.wr_data = alu_result;

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     inst_stall_i,
    input  logic [mips_pkg::XLEN-1:0] inst_sram_rdata_i,
    output logic [mips_pkg::XLEN-1:0] inst_sram_addr_o,
    output mips_pkg::instr_u          instr_o,
    output logic [mips_pkg::XLEN-1:0] instr_pc_o,
    output logic                      instr_valid_o
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc_q;

    assign inst_sram_addr_o = pc_q;  // no translation.

    ////////////////////
    // pc and valid bit
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            instr_valid_o <= 1'b0;
        end else if (inst_stall_i) begin
            instr_valid_o <= 1'b0;  // pc holds and a bubble enters.
        end else begin
            pc_q          <= pc_q + PC_STEP;
            instr_valid_o <= 1'b1;
        end
    end

    // word and its address.
    always_ff @(posedge clk) begin
        if (!inst_stall_i) begin
            instr_o    <= inst_sram_rdata_i;
            instr_pc_o <= pc_q;
        end
    end

endmodule

/* logic/mips_pkg.sv */
package mips_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int ALUOP_W    = 4;

    localparam logic [XLEN-1:0] RESET_PC = 32'hBFC0_0000;   // boot vector.
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    ////////////////////
    // opcodes and funct
    ////////////////////

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_SRL  = 6'h02;
    localparam logic [5:0] FUNCT_SRA  = 6'h03;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_NOR  = 6'h27;
    localparam logic [5:0] FUNCT_SLT  = 6'h2A;
    localparam logic [5:0] FUNCT_SLTU = 6'h2B;

    // alu operations.
    localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALUOP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALUOP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALUOP_W-1:0] ALU_NOR  = 4'd5;
    localparam logic [ALUOP_W-1:0] ALU_SLT  = 4'd6;
    localparam logic [ALUOP_W-1:0] ALU_SLTU = 4'd7;
    localparam logic [ALUOP_W-1:0] ALU_SLL  = 4'd8;
    localparam logic [ALUOP_W-1:0] ALU_SRL  = 4'd9;
    localparam logic [ALUOP_W-1:0] ALU_SRA  = 4'd10;

    // one instruction word, seen as R-format or I-format.
    typedef union packed {
        struct packed {
            logic [5:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [SHAMT_W-1:0]    shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [IMM_W-1:0]      imm;
        } i;
    } instr_u;

endpackage

/* logic/mips_top.sv */
`timescale 1ns/10ps

module mips_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    output logic [mips_pkg::XLEN-1:0]       inst_sram_addr_o,
    input  logic [mips_pkg::XLEN-1:0]       inst_sram_rdata_i,
    input  logic                            inst_stall_i,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]                      debug_wb_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_num_o,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_data_o
);
    import mips_pkg::*;

    instr_u                if_instr;
    logic [XLEN-1:0]       if_pc;
    logic                  if_valid;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic                  rf_wr_en;
    logic [REG_ADDR_W-1:0] rf_wr_addr;
    logic [XLEN-1:0]       rf_wr_data;

    decode_exec_if de_if ();
    exec_result_if er_if ();

    ////////////////////
    // pipeline
    ////////////////////

    fetch_unit u_fetch (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_stall_i      (inst_stall_i),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .instr_o           (if_instr),
        .instr_pc_o        (if_pc),
        .instr_valid_o     (if_valid)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_i       (if_instr),
        .instr_pc_i    (if_pc),
        .instr_valid_i (if_valid),
        .rs_addr_o     (rs_addr),
        .rt_addr_o     (rt_addr),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .fwd           (er_if.bypass),
        .to_ex         (de_if.decode)
    );

    execute_stage u_execute (
        .from_id (de_if.execute),
        .to_wb   (er_if.execute)
    );

    result_stage u_result (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .from_ex         (er_if.result),
        .rf_wr_en_o      (rf_wr_en),
        .rf_wr_addr_o    (rf_wr_addr),
        .rf_wr_data_o    (rf_wr_data),
        .debug_wb_pc_o   (debug_wb_pc_o),
        .debug_wb_wen_o  (debug_wb_wen_o),
        .debug_wb_num_o  (debug_wb_num_o),
        .debug_wb_data_o (debug_wb_data_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wr_en_i   (rf_wr_en),
        .wr_addr_i (rf_wr_addr),
        .wr_data_i (rf_wr_data)
    );

endmodule

/* logic/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_i,
    output logic [mips_pkg::XLEN-1:0]       rs_data_o,
    output logic [mips_pkg::XLEN-1:0]       rt_data_o,
    input  logic                            wr_en_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [mips_pkg::XLEN-1:0]       wr_data_i
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];
    logic            wr_live;

    assign wr_live = wr_en_i && (wr_addr_i != '0);  // r0 is never written.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // same-cycle write is passed straight through.
    assign rs_data_o = (rs_addr_i == '0)                    ? '0 :
                       (wr_live && (wr_addr_i == rs_addr_i)) ? wr_data_i :
                                                              regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0)                    ? '0 :
                       (wr_live && (wr_addr_i == rt_addr_i)) ? wr_data_i :
                                                              regs[rt_addr_i];

endmodule

/* logic/result_stage.sv */
`timescale 1ns/10ps

module result_stage (
    input  logic                            clk,
    input  logic                            rst_n_i,
    exec_result_if.result                   from_ex,
    output logic                            rf_wr_en_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rf_wr_addr_o,
    output logic [mips_pkg::XLEN-1:0]       rf_wr_data_o,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]                      debug_wb_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_num_o,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_data_o
);
    import mips_pkg::*;

    logic                  wr_en_q;
    logic [XLEN-1:0]       pc_q;
    logic [REG_ADDR_W-1:0] wr_addr_q;
    logic [XLEN-1:0]       wr_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= from_ex.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        pc_q      <= from_ex.pc;
        wr_addr_q <= from_ex.wr_addr;
        wr_data_q <= from_ex.wr_data;
    end

    assign rf_wr_en_o      = wr_en_q;
    assign rf_wr_addr_o    = wr_addr_q;
    assign rf_wr_data_o    = wr_data_q;

    // trace mirrors the register file write.
    assign debug_wb_pc_o   = pc_q;
    assign debug_wb_wen_o  = {4{wr_en_q}};
    assign debug_wb_num_o  = wr_addr_q;
    assign debug_wb_data_o = wr_data_q;

endmodule

/* test/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 35;

task automatic load_program();
    // name, instruction word, writes, expected register, expected value.
    add_row("addiu pos",   i_word(6'h09, 5'd0, 5'd1, 16'h7FFF), 1'b1, 5'd1, 32'h0000_7FFF);
    add_row("addiu sext",  i_word(6'h09, 5'd0, 5'd2, 16'h8000), 1'b1, 5'd2, 32'hFFFF_8000);
    add_row("addu fwd",    r_word(5'd1, 5'd2, 5'd3, 5'd0, 6'h21), 1'b1, 5'd3, 32'hFFFF_FFFF);
    add_row("lui top",     i_word(6'h0F, 5'd0, 5'd4, 16'h8000), 1'b1, 5'd4, 32'h8000_0000);
    add_row("addu wrap",   r_word(5'd4, 5'd3, 5'd5, 5'd0, 6'h21), 1'b1, 5'd5, 32'h7FFF_FFFF);
    add_row("subu wrap",   r_word(5'd1, 5'd2, 5'd6, 5'd0, 6'h23), 1'b1, 5'd6, 32'h0000_FFFF);
    add_row("subu neg",    r_word(5'd0, 5'd1, 5'd7, 5'd0, 6'h23), 1'b1, 5'd7, 32'hFFFF_8001);
    add_row("and",         r_word(5'd2, 5'd6, 5'd8, 5'd0, 6'h24), 1'b1, 5'd8, 32'h0000_8000);
    add_row("or",          r_word(5'd4, 5'd1, 5'd9, 5'd0, 6'h25), 1'b1, 5'd9, 32'h8000_7FFF);
    add_row("xor",         r_word(5'd9, 5'd7, 5'd10, 5'd0, 6'h26), 1'b1, 5'd10, 32'h7FFF_FFFE);
    add_row("nor",         r_word(5'd1, 5'd4, 5'd11, 5'd0, 6'h27), 1'b1, 5'd11, 32'h7FFF_8000);
    add_row("slt mixed",   r_word(5'd2, 5'd1, 5'd12, 5'd0, 6'h2A), 1'b1, 5'd12, 32'h0000_0001);
    add_row("sltu mixed",  r_word(5'd2, 5'd1, 5'd13, 5'd0, 6'h2B), 1'b1, 5'd13, 32'h0000_0000);
    add_row("sltu rev",    r_word(5'd1, 5'd2, 5'd14, 5'd0, 6'h2B), 1'b1, 5'd14, 32'h0000_0001);
    add_row("sll",         r_word(5'd0, 5'd1, 5'd15, 5'd4, 6'h00), 1'b1, 5'd15, 32'h0007_FFF0);
    add_row("srl",         r_word(5'd0, 5'd2, 5'd16, 5'd8, 6'h02), 1'b1, 5'd16, 32'h00FF_FF80);
    add_row("sra neg",     r_word(5'd0, 5'd2, 5'd17, 5'd8, 6'h03), 1'b1, 5'd17, 32'hFFFF_FF80);
    add_row("sra top",     r_word(5'd0, 5'd4, 5'd18, 5'd4, 6'h03), 1'b1, 5'd18, 32'hF800_0000);
    add_row("addiu minus", i_word(6'h09, 5'd1, 5'd19, 16'hFFFF), 1'b1, 5'd19, 32'h0000_7FFE);
    add_row("slti true",   i_word(6'h0A, 5'd2, 5'd20, 16'h8001), 1'b1, 5'd20, 32'h0000_0001);
    add_row("slti false",  i_word(6'h0A, 5'd1, 5'd21, 16'hFFFF), 1'b1, 5'd21, 32'h0000_0000);
    add_row("andi zext",   i_word(6'h0C, 5'd3, 5'd22, 16'h8F0F), 1'b1, 5'd22, 32'h0000_8F0F);
    add_row("ori zext",    i_word(6'h0D, 5'd4, 5'd23, 16'h8001), 1'b1, 5'd23, 32'h8000_8001);
    add_row("xori zext",   i_word(6'h0E, 5'd7, 5'd24, 16'hFFFF), 1'b1, 5'd24, 32'hFFFF_7FFE);
    add_row("lui rs set",  i_word(6'h0F, 5'd1, 5'd25, 16'hABCD), 1'b1, 5'd25, 32'hABCD_0000);
    add_row("dep addiu",   i_word(6'h09, 5'd25, 5'd26, 16'h1234), 1'b1, 5'd26, 32'hABCD_1234);
    add_row("dep xor",     r_word(5'd26, 5'd25, 5'd27, 5'd0, 6'h26), 1'b1, 5'd27, 32'h0000_1234);
    add_row("dep subu",    r_word(5'd27, 5'd26, 5'd27, 5'd0, 6'h23), 1'b1, 5'd27, 32'h5433_0000);
    add_row("dep addu",    r_word(5'd27, 5'd27, 5'd28, 5'd0, 6'h21), 1'b1, 5'd28, 32'hA866_0000);
    // r0 target, unknown opcode and unknown funct retire silently.
    add_row("r0 write",    i_word(6'h09, 5'd1, 5'd0, 16'h0055), 1'b0, 5'd0, 32'h0000_0000);
    add_row("r0 read",     r_word(5'd0, 5'd1, 5'd29, 5'd0, 6'h21), 1'b1, 5'd29, 32'h0000_7FFF);
    add_row("bad opcode",  i_word(6'h3F, 5'd1, 5'd29, 16'h1111), 1'b0, 5'd0, 32'h0000_0000);
    add_row("bad funct",   r_word(5'd1, 5'd2, 5'd29, 5'd0, 6'h18), 1'b0, 5'd0, 32'h0000_0000);
    add_row("r29 kept",    r_word(5'd29, 5'd0, 5'd30, 5'd0, 6'h25), 1'b1, 5'd30, 32'h0000_7FFF);
    add_row("final addu",  r_word(5'd30, 5'd28, 5'd31, 5'd0, 6'h21), 1'b1, 5'd31, 32'hA866_7FFF);
endtask

`endif

/* test/tb_mips_top.sv */
`timescale 1ns/10ps

module tb_mips_top;
    import mips_pkg::*;

    `include "tb_program.svh"

    localparam int          TIMEOUT_CYCLES = 4 * PROG_LEN + 16;
    localparam logic [31:0] LFSR_SEED      = 32'd65750;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic [XLEN-1:0]       inst_sram_addr_o;
    logic [XLEN-1:0]       inst_sram_rdata_i;
    logic                  inst_stall_i;
    logic [XLEN-1:0]       debug_wb_pc_o;
    logic [3:0]            debug_wb_wen_o;
    logic [REG_ADDR_W-1:0] debug_wb_num_o;
    logic [XLEN-1:0]       debug_wb_data_o;

    logic [XLEN-1:0]       prog_word [PROG_LEN];
    logic                  prog_wen  [PROG_LEN];
    logic [REG_ADDR_W-1:0] prog_num  [PROG_LEN];
    logic [XLEN-1:0]       prog_data [PROG_LEN];
    string                 prog_name [PROG_LEN];
    int                    row_count;
    int                    exp_rows [$];   // table rows still to retire.
    int                    cycle_count;
    logic [31:0]           lfsr;

    mips_top dut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .inst_stall_i      (inst_stall_i),
        .debug_wb_pc_o     (debug_wb_pc_o),
        .debug_wb_wen_o    (debug_wb_wen_o),
        .debug_wb_num_o    (debug_wb_num_o),
        .debug_wb_data_o   (debug_wb_data_o)
    );

    function automatic logic [31:0] r_word(input logic [4:0] rs, rt, rd, sa,
                                           input logic [5:0] funct);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic wen,
                           input logic [4:0] num, input logic [31:0] data);
        prog_name[row_count] = name;
        prog_word[row_count] = word;
        prog_wen[row_count]  = wen;
        prog_num[row_count]  = num;
        prog_data[row_count] = data;
        row_count++;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("** Error: %s %s: expected %h, actual %h",
                               name, field, expected, actual));
    endtask

    ////////////////////
    // clock and memory
    ////////////////////

    initial begin
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin : drive_inputs
        logic [31:0] offset;
        logic        bit_a;
        offset = (inst_sram_addr_o - RESET_PC) / PC_STEP;
        inst_sram_rdata_i = (offset < PROG_LEN) ? prog_word[offset] : '0;  // sll r0 past end.
        bit_a = lfsr[0];
        lfsr = lfsr_step(lfsr);
        inst_stall_i = bit_a & lfsr[0];
        lfsr = lfsr_step(lfsr);
    end

    ////////////////////
    // trace check
    ////////////////////

    always @(posedge clk) begin : check_trace
        int row;
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the write-back trace did not finish within the cycle limit");
        end
        if (rst_n_i && (debug_wb_wen_o != 4'h0)) begin
            assert (exp_rows.size() != 0) else
                fail_run("write-back seen after the last expected trace entry");
            row = exp_rows.pop_front();
            check_value(prog_name[row], "wen", 32'hF, debug_wb_wen_o);
            check_value(prog_name[row], "pc", RESET_PC + row * PC_STEP, debug_wb_pc_o);
            check_value(prog_name[row], "num", prog_num[row], debug_wb_num_o);
            check_value(prog_name[row], "data", prog_data[row], debug_wb_data_o);
        end
    end

    initial begin
        rst_n_i           = 1'b0;
        inst_stall_i      = 1'b0;
        inst_sram_rdata_i = '0;
        lfsr              = LFSR_SEED;
        cycle_count       = 0;
        row_count         = 0;
        load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            if (prog_wen[i]) begin
                exp_rows.push_back(i);
            end
        end
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            assert ((debug_wb_wen_o === 4'h0) && (inst_sram_addr_o === RESET_PC)) else
                fail_run("reset state wrong: write-back active or fetch not at boot vector");
        end
        rst_n_i = 1'b1;
        while (exp_rows.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);  // trailing zero words must stay silent.
        $display("NO ERRORS");
        $finish;
    end

endmodule
